// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Bus and storage widths
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WIDTH = 256;
    localparam int BEAT_WIDTH = 64;

    localparam int BEATS_PER_LINE = LINE_WIDTH / BEAT_WIDTH;
    localparam int OFFSET_BITS    = 5;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [WORD_WIDTH/8-1:0]   mbe_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [BEAT_WIDTH-1:0]     beat_t;

    // Cache controller
    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_WRITEBACK,
        CACHE_FILL,
        CACHE_RESPOND
    } cache_state_e;

    // Line port arbiter
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE_A,
        ARB_SERVE_B
    } arb_state_e;

    // Burst adaptor
    typedef enum logic [1:0] {
        BURST_IDLE,
        BURST_READ,
        BURST_WRITE,
        BURST_DONE
    } burst_state_e;

endpackage : mem_pkg

`default_nettype wire

// ==== cache.sv ====
`default_nettype none

module cache #(
    parameter int NUM_SETS = 8
) (
    input  wire logic            clk,
    input  wire logic            rst_i,

    // Word port toward the CPU
    input  wire logic            cpu_read_i,
    input  wire logic            cpu_write_i,
    input  wire mem_pkg::addr_t  cpu_addr_i,
    input  wire mem_pkg::word_t  cpu_wdata_i,
    input  wire mem_pkg::mbe_t   cpu_mbe_i,
    output logic                 cpu_resp_o,
    output mem_pkg::word_t       cpu_rdata_o,

    // Line port toward memory
    output logic                 line_read_o,
    output logic                 line_write_o,
    output mem_pkg::addr_t       line_addr_o,
    output mem_pkg::line_t       line_wdata_o,
    input  wire logic            line_resp_i,
    input  wire mem_pkg::line_t  line_rdata_i
);

    import mem_pkg::*;

    localparam int INDEX_BITS    = $clog2(NUM_SETS);
    localparam int TAG_BITS      = ADDR_WIDTH - OFFSET_BITS - INDEX_BITS;
    localparam int WORD_SEL_BITS = OFFSET_BITS - 2;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    tag_t                tag_arr  [NUM_SETS];
    line_t               data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    cache_state_e state_q;

    tag_t                     cpu_tag;
    index_t                   cpu_index;
    logic [WORD_SEL_BITS-1:0] cpu_word;
    logic                     cpu_req;
    logic                     hit;
    logic                     do_access;
    word_t                    read_word;
    line_t                    merged_line;

    // Address split: tag | index | word | byte
    assign cpu_tag   = cpu_addr_i[ADDR_WIDTH-1 -: TAG_BITS];
    assign cpu_index = cpu_addr_i[OFFSET_BITS +: INDEX_BITS];
    assign cpu_word  = cpu_addr_i[2 +: WORD_SEL_BITS];
    assign cpu_req   = cpu_read_i | cpu_write_i;
    assign hit       = valid_q[cpu_index] && (tag_arr[cpu_index] == cpu_tag);

    // Skip the cycle where resp is high, the request is still held then
    assign do_access = (state_q == CACHE_IDLE && cpu_req && hit && !cpu_resp_o) ||
                       (state_q == CACHE_RESPOND);

    assign read_word = data_arr[cpu_index][cpu_word*WORD_WIDTH +: WORD_WIDTH];

    // Byte merge of the store data into the resident line
    always_comb begin
        merged_line = data_arr[cpu_index];
        for (int i = 0; i < WORD_WIDTH/8; i++) begin
            if (cpu_mbe_i[i]) begin
                merged_line[cpu_word*WORD_WIDTH + i*8 +: 8] = cpu_wdata_i[i*8 +: 8];
            end
        end
    end

    assign line_read_o  = (state_q == CACHE_FILL);
    assign line_write_o = (state_q == CACHE_WRITEBACK);
    // Victim goes back to its own tag address
    assign line_addr_o  = line_write_o ?
                          {tag_arr[cpu_index], cpu_index, {OFFSET_BITS{1'b0}}} :
                          {cpu_tag, cpu_index, {OFFSET_BITS{1'b0}}};
    assign line_wdata_o = data_arr[cpu_index];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= CACHE_IDLE;
            cpu_resp_o <= 1'b0;
            valid_q    <= '0;
            dirty_q    <= '0;
        end else begin
            cpu_resp_o <= do_access;
            if (do_access && cpu_write_i) begin
                dirty_q[cpu_index] <= 1'b1;
            end
            case (state_q)
                CACHE_IDLE: begin
                    if (cpu_req && !cpu_resp_o && !hit) begin
                        state_q <= dirty_q[cpu_index] ? CACHE_WRITEBACK : CACHE_FILL;
                    end
                end
                CACHE_WRITEBACK: begin
                    if (line_resp_i) begin
                        dirty_q[cpu_index] <= 1'b0;
                        state_q            <= CACHE_FILL;
                    end
                end
                CACHE_FILL: begin
                    if (line_resp_i) begin
                        valid_q[cpu_index] <= 1'b1;
                        state_q            <= CACHE_RESPOND;
                    end
                end
                CACHE_RESPOND: state_q <= CACHE_IDLE;
                default:       state_q <= CACHE_IDLE;
            endcase
        end
    end

    // Tag, line storage and read data
    always_ff @(posedge clk) begin
        if (state_q == CACHE_FILL && line_resp_i) begin
            data_arr[cpu_index] <= line_rdata_i;
            tag_arr[cpu_index]  <= cpu_tag;
        end
        if (do_access) begin
            cpu_rdata_o <= read_word;
            if (cpu_write_i) begin
                data_arr[cpu_index] <= merged_line;
            end
        end
    end

endmodule : cache

`default_nettype wire

// ==== mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input  wire logic            clk,
    input  wire logic            rst_i,

    // Client a
    input  wire logic            a_read_i,
    input  wire logic            a_write_i,
    input  wire mem_pkg::addr_t  a_addr_i,
    input  wire mem_pkg::line_t  a_wdata_i,
    output logic                 a_resp_o,
    output mem_pkg::line_t       a_rdata_o,

    // Client b
    input  wire logic            b_read_i,
    input  wire logic            b_write_i,
    input  wire mem_pkg::addr_t  b_addr_i,
    input  wire mem_pkg::line_t  b_wdata_i,
    output logic                 b_resp_o,
    output mem_pkg::line_t       b_rdata_o,

    // Shared line port
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output mem_pkg::addr_t       mem_addr_o,
    output mem_pkg::line_t       mem_wdata_o,
    input  wire logic            mem_resp_i,
    input  wire mem_pkg::line_t  mem_rdata_i
);

    import mem_pkg::*;

    arb_state_e state_q;
    logic       last_a_q;
    logic       a_req;
    logic       b_req;
    logic       grant_a;
    logic       grant_b;

    assign a_req   = a_read_i | a_write_i;
    assign b_req   = b_read_i | b_write_i;
    assign grant_a = (state_q == ARB_SERVE_A);
    assign grant_b = (state_q == ARB_SERVE_B);

    // a wins a tie unless it was served last
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= ARB_IDLE;
            last_a_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (a_req && (!b_req || !last_a_q)) begin
                        state_q  <= ARB_SERVE_A;
                        last_a_q <= 1'b1;
                    end else if (b_req) begin
                        state_q  <= ARB_SERVE_B;
                        last_a_q <= 1'b0;
                    end
                end
                ARB_SERVE_A, ARB_SERVE_B: begin
                    if (mem_resp_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Only the granted client reaches the adaptor
    assign mem_read_o  = (grant_a & a_read_i)  | (grant_b & b_read_i);
    assign mem_write_o = (grant_a & a_write_i) | (grant_b & b_write_i);
    assign mem_addr_o  = grant_b ? b_addr_i  : a_addr_i;
    assign mem_wdata_o = grant_b ? b_wdata_i : a_wdata_i;

    assign a_resp_o  = grant_a & mem_resp_i;
    assign b_resp_o  = grant_b & mem_resp_i;
    assign a_rdata_o = mem_rdata_i;
    assign b_rdata_o = mem_rdata_i;

endmodule : mem_arbiter

`default_nettype wire

// ==== cacheline_adaptor.sv ====
`default_nettype none

module cacheline_adaptor (
    input  wire logic            clk,
    input  wire logic            rst_i,

    // Line side
    input  wire logic            line_read_i,
    input  wire logic            line_write_i,
    input  wire mem_pkg::addr_t  line_addr_i,
    input  wire mem_pkg::line_t  line_wdata_i,
    output logic                 line_resp_o,
    output mem_pkg::line_t       line_rdata_o,

    // Burst side, 64 bits per beat
    output logic                 burst_read_o,
    output logic                 burst_write_o,
    output mem_pkg::addr_t       burst_addr_o,
    output mem_pkg::beat_t       burst_wdata_o,
    input  wire logic            burst_resp_i,
    input  wire mem_pkg::beat_t  burst_rdata_i
);

    import mem_pkg::*;

    localparam int CNT_BITS = $clog2(BEATS_PER_LINE);

    burst_state_e        state_q;
    logic [CNT_BITS-1:0] beat_cnt_q;
    logic                last_beat;
    line_t               line_buf;
    addr_t               addr_q;

    assign last_beat = burst_resp_i && (beat_cnt_q == CNT_BITS'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= BURST_IDLE;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                BURST_IDLE: begin
                    beat_cnt_q <= '0;
                    if (line_read_i) begin
                        state_q <= BURST_READ;
                    end else if (line_write_i) begin
                        state_q <= BURST_WRITE;
                    end
                end
                BURST_READ, BURST_WRITE: begin
                    if (burst_resp_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= BURST_DONE;
                    end
                end
                BURST_DONE: state_q <= BURST_IDLE;
                default:    state_q <= BURST_IDLE;
            endcase
        end
    end

    // Lowest beat first in both directions
    always_ff @(posedge clk) begin
        if (state_q == BURST_IDLE) begin
            addr_q   <= {line_addr_i[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            line_buf <= line_wdata_i;
        end else if (state_q == BURST_READ && burst_resp_i) begin
            line_buf <= {burst_rdata_i, line_buf[LINE_WIDTH-1:BEAT_WIDTH]};
        end else if (state_q == BURST_WRITE && burst_resp_i) begin
            line_buf <= {{BEAT_WIDTH{1'b0}}, line_buf[LINE_WIDTH-1:BEAT_WIDTH]};
        end
    end

    assign burst_read_o  = (state_q == BURST_READ);
    assign burst_write_o = (state_q == BURST_WRITE);
    assign burst_addr_o  = addr_q;
    assign burst_wdata_o = line_buf[BEAT_WIDTH-1:0];

    // One cycle after the last beat
    assign line_resp_o  = (state_q == BURST_DONE);
    assign line_rdata_o = line_buf;

endmodule : cacheline_adaptor

`default_nettype wire

// ==== mem_subsystem.sv ====
`default_nettype none

module mem_subsystem #(
    parameter int NUM_SETS = 8
) (
    input  wire logic            clk,
    input  wire logic            rst_i,

    // Port a, fetch side
    input  wire logic            a_read_i,
    input  wire logic            a_write_i,
    input  wire mem_pkg::addr_t  a_addr_i,
    input  wire mem_pkg::word_t  a_wdata_i,
    input  wire mem_pkg::mbe_t   a_mbe_i,
    output logic                 a_resp_o,
    output mem_pkg::word_t       a_rdata_o,

    // Port b, load/store side
    input  wire logic            b_read_i,
    input  wire logic            b_write_i,
    input  wire mem_pkg::addr_t  b_addr_i,
    input  wire mem_pkg::word_t  b_wdata_i,
    input  wire mem_pkg::mbe_t   b_mbe_i,
    output logic                 b_resp_o,
    output mem_pkg::word_t       b_rdata_o,

    // Burst memory
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output mem_pkg::addr_t       mem_addr_o,
    output mem_pkg::beat_t       mem_wdata_o,
    input  wire logic            mem_resp_i,
    input  wire mem_pkg::beat_t  mem_rdata_i
);

    import mem_pkg::*;

    // Cache a to arbiter
    logic  a_line_read;
    logic  a_line_write;
    addr_t a_line_addr;
    line_t a_line_wdata;
    logic  a_line_resp;
    line_t a_line_rdata;

    // Cache b to arbiter
    logic  b_line_read;
    logic  b_line_write;
    addr_t b_line_addr;
    line_t b_line_wdata;
    logic  b_line_resp;
    line_t b_line_rdata;

    // Arbiter to adaptor
    logic  arb_read;
    logic  arb_write;
    addr_t arb_addr;
    line_t arb_wdata;
    logic  arb_resp;
    line_t arb_rdata;

    cache #(
        .NUM_SETS(NUM_SETS)
    ) cache_a (
        .clk(clk),
        .rst_i(rst_i),
        .cpu_read_i(a_read_i),
        .cpu_write_i(a_write_i),
        .cpu_addr_i(a_addr_i),
        .cpu_wdata_i(a_wdata_i),
        .cpu_mbe_i(a_mbe_i),
        .cpu_resp_o(a_resp_o),
        .cpu_rdata_o(a_rdata_o),
        .line_read_o(a_line_read),
        .line_write_o(a_line_write),
        .line_addr_o(a_line_addr),
        .line_wdata_o(a_line_wdata),
        .line_resp_i(a_line_resp),
        .line_rdata_i(a_line_rdata)
    );

    cache #(
        .NUM_SETS(NUM_SETS)
    ) cache_b (
        .clk(clk),
        .rst_i(rst_i),
        .cpu_read_i(b_read_i),
        .cpu_write_i(b_write_i),
        .cpu_addr_i(b_addr_i),
        .cpu_wdata_i(b_wdata_i),
        .cpu_mbe_i(b_mbe_i),
        .cpu_resp_o(b_resp_o),
        .cpu_rdata_o(b_rdata_o),
        .line_read_o(b_line_read),
        .line_write_o(b_line_write),
        .line_addr_o(b_line_addr),
        .line_wdata_o(b_line_wdata),
        .line_resp_i(b_line_resp),
        .line_rdata_i(b_line_rdata)
    );

    mem_arbiter mem_arbiter (
        .clk(clk),
        .rst_i(rst_i),
        .a_read_i(a_line_read),
        .a_write_i(a_line_write),
        .a_addr_i(a_line_addr),
        .a_wdata_i(a_line_wdata),
        .a_resp_o(a_line_resp),
        .a_rdata_o(a_line_rdata),
        .b_read_i(b_line_read),
        .b_write_i(b_line_write),
        .b_addr_i(b_line_addr),
        .b_wdata_i(b_line_wdata),
        .b_resp_o(b_line_resp),
        .b_rdata_o(b_line_rdata),
        .mem_read_o(arb_read),
        .mem_write_o(arb_write),
        .mem_addr_o(arb_addr),
        .mem_wdata_o(arb_wdata),
        .mem_resp_i(arb_resp),
        .mem_rdata_i(arb_rdata)
    );

    cacheline_adaptor cacheline_adaptor (
        .clk(clk),
        .rst_i(rst_i),
        .line_read_i(arb_read),
        .line_write_i(arb_write),
        .line_addr_i(arb_addr),
        .line_wdata_i(arb_wdata),
        .line_resp_o(arb_resp),
        .line_rdata_o(arb_rdata),
        .burst_read_o(mem_read_o),
        .burst_write_o(mem_write_o),
        .burst_addr_o(mem_addr_o),
        .burst_wdata_o(mem_wdata_o),
        .burst_resp_i(mem_resp_i),
        .burst_rdata_i(mem_rdata_i)
    );

endmodule : mem_subsystem

`default_nettype wire

// ==== mem_subsystem_assertions.sv ====
`default_nettype none

module mem_subsystem_assertions (
    input wire logic            clk,
    input wire logic            rst_i,
    input wire logic            a_read_i,
    input wire logic            a_write_i,
    input wire logic            a_resp_i,
    input wire logic            b_read_i,
    input wire logic            b_write_i,
    input wire logic            b_resp_i,
    input wire logic            mem_read_i,
    input wire logic            mem_write_i,
    input wire mem_pkg::addr_t  mem_addr_i
);

    a_no_rw: assert property (@(posedge clk) disable iff (rst_i) !(a_read_i && a_write_i))
        else $error("port a has read and write high together");
    b_no_rw: assert property (@(posedge clk) disable iff (rst_i) !(b_read_i && b_write_i))
        else $error("port b has read and write high together");

    // Resp is a single-cycle pulse
    a_resp_pulse: assert property (@(posedge clk) disable iff (rst_i) a_resp_i |=> !a_resp_i)
        else $error("port a resp longer than one cycle");
    b_resp_pulse: assert property (@(posedge clk) disable iff (rst_i) b_resp_i |=> !b_resp_i)
        else $error("port b resp longer than one cycle");

    mem_one_dir: assert property (@(posedge clk) disable iff (rst_i)
        !(mem_read_i && mem_write_i))
        else $error("memory read and write high together");

    // Bursts are always separated by an idle cycle
    mem_addr_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem_read_i || mem_write_i) |=> !(mem_read_i || mem_write_i) || $stable(mem_addr_i))
        else $error("memory address changed during a burst");

endmodule : mem_subsystem_assertions

bind mem_subsystem mem_subsystem_assertions mem_subsystem_assertions_inst (
    .clk(clk),
    .rst_i(rst_i),
    .a_read_i(a_read_i),
    .a_write_i(a_write_i),
    .a_resp_i(a_resp_o),
    .b_read_i(b_read_i),
    .b_write_i(b_write_i),
    .b_resp_i(b_resp_o),
    .mem_read_i(mem_read_o),
    .mem_write_i(mem_write_o),
    .mem_addr_i(mem_addr_o)
);

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`default_nettype none

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam int MEM_BYTES = 4096;
    localparam int MAX_OPS   = 64;
    localparam int NUM_SETS  = 8;

    logic  clk = 1'b0;
    logic  rst_i;

    logic  a_read_i;
    logic  a_write_i;
    addr_t a_addr_i;
    word_t a_wdata_i;
    mbe_t  a_mbe_i;
    logic  a_resp_o;
    word_t a_rdata_o;

    logic  b_read_i;
    logic  b_write_i;
    addr_t b_addr_i;
    word_t b_wdata_i;
    mbe_t  b_mbe_i;
    logic  b_resp_o;
    word_t b_rdata_o;

    logic  mem_read_o;
    logic  mem_write_o;
    addr_t mem_addr_o;
    beat_t mem_wdata_o;
    logic  mem_resp_i;
    beat_t mem_rdata_i;

    logic [7:0] mem_bytes [MEM_BYTES];
    word_t      shadow [MEM_BYTES/4];

    // Line number held in each set of cache a and cache b
    addr_t      held_line  [2][NUM_SETS];
    logic       held_valid [2][NUM_SETS];

    // Operations from the data file
    // Port code 0 for a, 1 for b, 2 for both
    logic [1:0] op_port   [MAX_OPS];
    logic       op_wr     [MAX_OPS];
    addr_t      op_addr   [MAX_OPS];
    word_t      op_wdata  [MAX_OPS];
    mbe_t       op_mbe    [MAX_OPS];
    word_t      op_expect [MAX_OPS];

    int     num_ops       = 0;
    int     error_count   = 0;
    int     timeout_count = 0;
    int     cycle_count   = 0;
    int     cycle_limit   = 0;
    int     burst_count   = 0;
    integer seed;

    always #50 clk = ~clk;

    mem_subsystem #(
        .NUM_SETS(NUM_SETS)
    ) mem_subsystem_inst (
        .clk(clk),
        .rst_i(rst_i),
        .a_read_i(a_read_i),
        .a_write_i(a_write_i),
        .a_addr_i(a_addr_i),
        .a_wdata_i(a_wdata_i),
        .a_mbe_i(a_mbe_i),
        .a_resp_o(a_resp_o),
        .a_rdata_o(a_rdata_o),
        .b_read_i(b_read_i),
        .b_write_i(b_write_i),
        .b_addr_i(b_addr_i),
        .b_wdata_i(b_wdata_i),
        .b_mbe_i(b_mbe_i),
        .b_resp_o(b_resp_o),
        .b_rdata_o(b_rdata_o),
        .mem_read_o(mem_read_o),
        .mem_write_o(mem_write_o),
        .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_resp_i(mem_resp_i),
        .mem_rdata_i(mem_rdata_i)
    );

    // Power-on contents of every word
    function automatic word_t init_word(input int addr);
        return word_t'(addr) ^ 32'hA5A50000;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t data, input mbe_t mbe);
        word_t result;
        result = old_w;
        for (int i = 0; i < 4; i++) begin
            if (mbe[i]) begin
                result[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // Direct-mapped placement with one line per set
    function automatic logic line_cached(input int port, input addr_t addr);
        addr_t line_num;
        int    set_idx;
        line_num = addr >> OFFSET_BITS;
        set_idx  = int'(line_num % NUM_SETS);
        return held_valid[port][set_idx] && (held_line[port][set_idx] == line_num);
    endfunction

    task automatic note_access(input int port, input addr_t addr);
        addr_t line_num;
        int    set_idx;
        line_num = addr >> OFFSET_BITS;
        set_idx  = int'(line_num % NUM_SETS);
        held_valid[port][set_idx] = 1'b1;
        held_line[port][set_idx]  = line_num;
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: t=%0t %s returned %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_addr(input addr_t addr);
        if (addr[OFFSET_BITS-1:0] != '0 || addr >= addr_t'(MEM_BYTES)) begin
            error_count++;
            $display("ERROR: t=%0t burst address %h not line-aligned or outside memory",
                     $time, addr);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            timeout_count = 1;
            $display("Timeout: no response after %0d cycles, the simulation hung", cycle_count);
            $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Burst memory answering after 0 to 3 wait cycles
    task automatic serve_burst;
        addr_t base;
        logic  is_write;
        int    waits;
        int    idx;
        beat_t beat;
        base     = mem_addr_o;
        is_write = mem_write_o;
        check_addr(base);
        burst_count++;
        waits = $random(seed) & 3;
        repeat (waits) begin
            @(posedge clk);
            #10;
        end
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            for (int k = 0; k < 8; k++) begin
                idx = (int'(base[11:0]) + b*8 + k) % MEM_BYTES;
                if (is_write) begin
                    mem_bytes[idx] = mem_wdata_o[k*8 +: 8];
                end else begin
                    beat[k*8 +: 8] = mem_bytes[idx];
                end
            end
            mem_resp_i  = 1'b1;
            mem_rdata_i = is_write ? '0 : beat;
            @(posedge clk);
            #10;
        end
        mem_resp_i  = 1'b0;
        mem_rdata_i = '0;
    endtask

    initial begin
        word_t w;
        mem_resp_i  = 1'b0;
        mem_rdata_i = '0;
        for (int i = 0; i < MEM_BYTES; i += 4) begin
            w = init_word(i);
            for (int j = 0; j < 4; j++) begin
                mem_bytes[i+j] = w[j*8 +: 8];
            end
        end
        forever begin
            @(posedge clk);
            #10;
            if (!rst_i && (mem_read_o || mem_write_o)) begin
                serve_burst();
            end
        end
    end

    // Data file columns are port op addr wdata mbe expected
    task automatic load_testdata;
        int    fd;
        int    n;
        string line;
        string port_s;
        string op_s;
        addr_t addr;
        word_t wdata;
        mbe_t  mbe;
        word_t expect_w;
        fd = $fopen("mem_subsystem_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open mem_subsystem_testdata.txt, no operations were run");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h", port_s, op_s, addr, wdata, mbe,
                                expect_w);
                    if (n == 6 && num_ops < MAX_OPS) begin
                        op_port[num_ops]   = (port_s == "a") ? 2'd0 :
                                             (port_s == "b") ? 2'd1 : 2'd2;
                        op_wr[num_ops]     = (op_s == "w");
                        op_addr[num_ops]   = addr;
                        op_wdata[num_ops]  = wdata;
                        op_mbe[num_ops]    = mbe;
                        op_expect[num_ops] = expect_w;
                        num_ops++;
                    end
                end
            end
            $fclose(fd);
            if (num_ops == 0) begin
                error_count++;
                $display("The data file holds no operations, nothing was tested");
            end
        end
    endtask

    task automatic run_op(input int idx);
        logic a_busy;
        logic b_busy;
        logic expect_hit;
        int   bursts_before;
        int   widx;
        widx = int'(op_addr[idx][11:2]);
        if (op_wr[idx]) begin
            shadow[widx] = merge_bytes(shadow[widx], op_wdata[idx], op_mbe[idx]);
        end else if (op_expect[idx] !== shadow[widx]) begin
            error_count++;
            $display("Data file operation %0d expects %h but the reference model holds %h",
                     idx, op_expect[idx], shadow[widx]);
        end
        a_busy = (op_port[idx] != 2'd1);
        b_busy = (op_port[idx] != 2'd0);
        expect_hit    = (!a_busy || line_cached(0, op_addr[idx])) &&
                        (!b_busy || line_cached(1, op_addr[idx]));
        bursts_before = burst_count;
        if (a_busy) begin
            a_read_i  = !op_wr[idx];
            a_write_i = op_wr[idx];
            a_addr_i  = op_addr[idx];
            a_wdata_i = op_wdata[idx];
            a_mbe_i   = op_mbe[idx];
        end
        if (b_busy) begin
            b_read_i  = !op_wr[idx];
            b_write_i = op_wr[idx];
            b_addr_i  = op_addr[idx];
            b_wdata_i = op_wdata[idx];
            b_mbe_i   = op_mbe[idx];
        end
        // Ports finish in any order
        while (a_busy || b_busy) begin
            @(posedge clk);
            #10;
            if (a_busy && a_resp_o) begin
                a_busy    = 1'b0;
                a_read_i  = 1'b0;
                a_write_i = 1'b0;
                if (!op_wr[idx]) begin
                    check_word(a_rdata_o, op_expect[idx],
                               $sformatf("port a read of %h", op_addr[idx]));
                end
            end
            if (b_busy && b_resp_o) begin
                b_busy    = 1'b0;
                b_read_i  = 1'b0;
                b_write_i = 1'b0;
                if (!op_wr[idx]) begin
                    check_word(b_rdata_o, op_expect[idx],
                               $sformatf("port b read of %h", op_addr[idx]));
                end
            end
        end
        // A resident line is served without any memory traffic
        if (expect_hit && burst_count != bursts_before) begin
            error_count++;
            $display("ERROR: t=%0t access to %h should hit but started a memory burst",
                     $time, op_addr[idx]);
        end
        if (op_port[idx] != 2'd1) begin
            note_access(0, op_addr[idx]);
        end
        if (op_port[idx] != 2'd0) begin
            note_access(1, op_addr[idx]);
        end
    endtask

    initial begin
        seed      = 32'ha311ea5a;
        rst_i     = 1'b1;
        a_read_i  = 1'b0;
        a_write_i = 1'b0;
        a_addr_i  = '0;
        a_wdata_i = '0;
        a_mbe_i   = '0;
        b_read_i  = 1'b0;
        b_write_i = 1'b0;
        b_addr_i  = '0;
        b_wdata_i = '0;
        b_mbe_i   = '0;
        for (int i = 0; i < MEM_BYTES/4; i++) begin
            shadow[i] = init_word(i*4);
        end
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                held_valid[p][s] = 1'b0;
                held_line[p][s]  = '0;
            end
        end
        load_testdata();
        cycle_limit = num_ops*40 + 100;
        repeat (3) @(posedge clk);
        #10;
        rst_i = 1'b0;
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

`default_nettype wire

// ==== mem_subsystem_testdata.txt ====
# port(a/b/both) op(r/w) addr(hex) wdata(hex) mbe(hex) expected_read(hex)
# Writes carry 00000000 as expected value, it is not checked
a r 00000040 00000000 0 a5a50040
a r 00000040 00000000 0 a5a50040
b r 00000044 00000000 0 a5a50044
b r 00000044 00000000 0 a5a50044
# Byte-enabled writes on port b
b w 00000048 11223344 3 00000000
b r 00000048 00000000 0 a5a53344
b w 0000004c deadbeef c 00000000
b r 0000004c 00000000 0 dead004c
# Eviction of a dirty line and refill
a w 00000080 cafef00d f 00000000
a r 00000180 00000000 0 a5a50180
a r 00000080 00000000 0 cafef00d
a r 00000084 00000000 0 a5a50084
# Sharing through memory between the two caches
a w 00000310 0badc0de f 00000000
a r 00000410 00000000 0 a5a50410
b r 00000310 00000000 0 0badc0de
b r 00000140 00000000 0 a5a50140
a r 00000240 00000000 0 a5a50240
a r 00000048 00000000 0 a5a53344
a r 0000004c 00000000 0 dead004c
# Simultaneous requests on both ports
both r 00000500 00000000 0 a5a50500
both r 00000500 00000000 0 a5a50500
both r 00000a28 00000000 0 a5a50a28
a w 00000520 12345678 f 00000000
b w 00000624 87654321 f 00000000
both r 00000720 00000000 0 a5a50720
b r 00000520 00000000 0 12345678
a r 00000624 00000000 0 87654321
both r 00000ffc 00000000 0 a5a50ffc
b w 00000ff8 00ff00ff 5 00000000
b r 00000ff8 00000000 0 a5ff0fff

// ==== project.f ====
mem_pkg.sv
cache.sv
mem_arbiter.sv
cacheline_adaptor.sv
mem_subsystem.sv
mem_subsystem_assertions.sv
tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert \
    --top-module tb_mem_subsystem \
    -f project.f \
    -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem 2>&1 | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
